// ==== include/exec_writeback_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// configuration macros for the execute and write-back slice
// data width, rob tag width, memory read latency
//////////////////////////////////////////////////////////////////////

`ifndef EXEC_WRITEBACK_CFG_SVH
`define EXEC_WRITEBACK_CFG_SVH

// data and address width
`define XLEN 32

// width of the rob tag that names a result
`define ROB_TAG_LEN 5

// cycles from mem_read to mem_data
// fixed by the load unit, one request in flight at a time
`define MEM_LATENCY 1

`endif

// ==== design/exec_writeback_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types of the execute and write-back slice
// data word, rob tag, alu and load op encodings, cdb packet
//////////////////////////////////////////////////////////////////////

`include "exec_writeback_cfg.svh"

package exec_writeback_pkg;

	typedef logic [`XLEN-1:0] xlen_t;
	typedef logic [`ROB_TAG_LEN-1:0] rob_tag_t;

	// raw op field as it arrives with every issue
	typedef logic [3:0] op_field_t;

	// alu function select, op field of a non-load issue
	typedef enum logic [3:0] {
		ALU_ADD  = 4'h0,
		ALU_SUB  = 4'h1,
		ALU_AND  = 4'h2,
		ALU_OR   = 4'h3,
		ALU_XOR  = 4'h4,
		ALU_SLL  = 4'h5,
		ALU_SRL  = 4'h6,
		ALU_SRA  = 4'h7,
		ALU_SLT  = 4'h8,
		ALU_SLTU = 4'h9
	} alu_func_t;

	// access size of a load
	typedef enum logic [1:0] {
		MEM_BYTE = 2'h0,
		MEM_HALF = 2'h1,
		MEM_WORD = 2'h2
	} mem_size_t;

	// op field of a load issue, msb first
	typedef struct packed {
		logic      is_unsigned;
		mem_size_t size;
		logic      spare;
	} load_op_t;

	// one common data bus beat
	typedef struct packed {
		logic     valid;
		rob_tag_t rob_tag;
		xlen_t    value;
	} cdb_packet_t;

endpackage

// ==== design/exec_if.sv ====
//////////////////////////////////////////////////////////////////////
// issue interface, shared by the alu and load units
// write-slot interface between one unit and the cdb arbiter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// issue bus, operands already read
//////////////////////////////////////////////////////////////////////
interface issue_if import exec_writeback_pkg::*; ();

	logic      valid;
	// steers the issue to the load unit
	logic      is_load;
	rob_tag_t  rob_tag;
	// alu_func_t or load_op_t, depending on is_load
	op_field_t op;
	xlen_t     rs1_value;
	xlen_t     rs2_value;
	xlen_t     imm;

	// both units only listen, each decides its own accept
	modport sink (
		input valid,
		input is_load,
		input rob_tag,
		input op,
		input rs1_value,
		input rs2_value,
		input imm
	);

endinterface

//////////////////////////////////////////////////////////////////////
// result slot, held until written
//////////////////////////////////////////////////////////////////////
interface wr_slot_if import exec_writeback_pkg::*; ();

	logic     valid;
	rob_tag_t rob_tag;
	xlen_t    value;
	// slot granted the cdb this cycle
	logic     written;

	modport source (
		output valid,
		output rob_tag,
		output value,
		input  written
	);

	modport arb (
		input  valid,
		input  rob_tag,
		input  value,
		output written
	);

endinterface

// ==== design/alu_unit.sv ====
//////////////////////////////////////////////////////////////////////
// integer alu with its result slot
// accept rule and ready for the alu path
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "exec_writeback_cfg.svh"

module alu_unit import exec_writeback_pkg::*; (
	input logic          clock,
	input logic          reset,
	issue_if.sink        issue,
	wr_slot_if.source    slot,
	output logic         alu_ready
);

	alu_func_t func;
	xlen_t     result;
	logic [4:0] shamt;
	logic      accept;

	// slot register
	logic      slot_valid;
	rob_tag_t  slot_rob_tag;
	xlen_t     slot_value;

	//////////////////////////////////////////////////////////////////////
	// alu datapath
	//////////////////////////////////////////////////////////////////////

	assign func  = alu_func_t'(issue.op);
	// shift amount from the low bits of rs2
	assign shamt = issue.rs2_value[4:0];

	always_comb begin
		case (func)
			ALU_ADD:  result = issue.rs1_value + issue.rs2_value;
			ALU_SUB:  result = issue.rs1_value - issue.rs2_value;
			ALU_AND:  result = issue.rs1_value & issue.rs2_value;
			ALU_OR:   result = issue.rs1_value | issue.rs2_value;
			ALU_XOR:  result = issue.rs1_value ^ issue.rs2_value;
			ALU_SLL:  result = issue.rs1_value << shamt;
			ALU_SRL:  result = issue.rs1_value >> shamt;
			ALU_SRA:  result = xlen_t'($signed(issue.rs1_value) >>> shamt);
			// compare results are a single bit, zero filled
			ALU_SLT: begin
				result = {{(`XLEN-1){1'b0}},
					$signed(issue.rs1_value) < $signed(issue.rs2_value)};
			end
			ALU_SLTU: begin
				result = {{(`XLEN-1){1'b0}}, issue.rs1_value < issue.rs2_value};
			end
			// unused encodings give zero
			default:  result = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// slot and back-pressure
	//////////////////////////////////////////////////////////////////////

	// free when empty or leaving on the cdb this cycle
	assign alu_ready = ~slot_valid | slot.written;
	assign accept    = issue.valid & ~issue.is_load & alu_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			slot_valid <= 1'b0;
		end else if (accept) begin
			slot_valid <= 1'b1;
		end else if (slot.written) begin
			slot_valid <= 1'b0;
		end
	end

	// payload only moves on accept
	always_ff @(posedge clock) begin
		if (accept) begin
			slot_rob_tag <= issue.rob_tag;
			slot_value   <= result;
		end
	end

	assign slot.valid   = slot_valid;
	assign slot.rob_tag = slot_rob_tag;
	assign slot.value   = slot_value;

endmodule

// ==== design/load_unit.sv ====
//////////////////////////////////////////////////////////////////////
// load path: address calculation, single-beat memory read,
// lane select with sign or zero extension, load result slot
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "exec_writeback_cfg.svh"

module load_unit import exec_writeback_pkg::*; (
	input logic          clock,
	input logic          reset,
	issue_if.sink        issue,
	wr_slot_if.source    slot,
	output logic         load_ready,
	output logic         mem_read,
	output xlen_t        mem_addr,
	input xlen_t         mem_data
);

	logic     accept;
	xlen_t    eff_addr;

	// request in flight
	logic     pending;
	rob_tag_t pend_rob_tag;
	load_op_t pend_op;
	logic [1:0] pend_offset;
	xlen_t    pend_addr;

	// return data shaping
	logic [7:0]  lane_byte;
	logic [15:0] lane_half;
	xlen_t       load_value;

	// slot register
	logic     slot_valid;
	rob_tag_t slot_rob_tag;
	xlen_t    slot_value;

	//////////////////////////////////////////////////////////////////////
	// accept and request
	//////////////////////////////////////////////////////////////////////

	assign eff_addr = issue.rs1_value + issue.imm;

	// one request at a time, slot must be free or draining
	assign load_ready = ~pending & (~slot_valid | slot.written);
	assign accept     = issue.valid & issue.is_load & load_ready;

	// mem_read lasts exactly one cycle after accept
	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
		end else begin
			pending <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			pend_rob_tag <= issue.rob_tag;
			pend_op      <= load_op_t'(issue.op);
			pend_offset  <= eff_addr[1:0];
			// memory sees word addresses only
			pend_addr    <= {eff_addr[`XLEN-1:2], 2'b00};
		end
	end

	assign mem_read = pending;
	assign mem_addr = pend_addr;

	//////////////////////////////////////////////////////////////////////
	// return path
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// byte lane by offset, half lane by offset msb
		lane_byte = mem_data[{pend_offset, 3'b000} +: 8];
		lane_half = pend_offset[1] ? mem_data[31:16] : mem_data[15:0];
		case (pend_op.size)
			MEM_BYTE: begin
				load_value = pend_op.is_unsigned ?
					{{(`XLEN-8){1'b0}}, lane_byte} :
					{{(`XLEN-8){lane_byte[7]}}, lane_byte};
			end
			MEM_HALF: begin
				load_value = pend_op.is_unsigned ?
					{{(`XLEN-16){1'b0}}, lane_half} :
					{{(`XLEN-16){lane_half[15]}}, lane_half};
			end
			default:  load_value = mem_data;
		endcase
	end

	// data returns the cycle after mem_read, captured here
	always_ff @(posedge clock) begin
		if (reset) begin
			slot_valid <= 1'b0;
		end else if (pending) begin
			slot_valid <= 1'b1;
		end else if (slot.written) begin
			slot_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (pending) begin
			slot_rob_tag <= pend_rob_tag;
			slot_value   <= load_value;
		end
	end

	assign slot.valid   = slot_valid;
	assign slot.rob_tag = slot_rob_tag;
	assign slot.value   = slot_value;

endmodule

// ==== design/cdb_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// write stage: picks one result slot for the cdb
// load slot first, written pulse to the winner only
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cdb_arbiter import exec_writeback_pkg::*; (
	wr_slot_if.arb       alu_slot,
	wr_slot_if.arb       load_slot,
	output logic         cdb_valid,
	output rob_tag_t     cdb_rob_tag,
	output xlen_t        cdb_value
);

	cdb_packet_t cdb;
	logic        grant_load;
	logic        grant_alu;

	// fixed priority, load beats alu
	assign grant_load = load_slot.valid;
	assign grant_alu  = alu_slot.valid & ~load_slot.valid;

	always_comb begin
		cdb = '0;
		if (grant_load) begin
			cdb.valid   = 1'b1;
			cdb.rob_tag = load_slot.rob_tag;
			cdb.value   = load_slot.value;
		end else if (grant_alu) begin
			cdb.valid   = 1'b1;
			cdb.rob_tag = alu_slot.rob_tag;
			cdb.value   = alu_slot.value;
		end
	end

	// the losing slot holds and retries next cycle
	assign load_slot.written = grant_load;
	assign alu_slot.written  = grant_alu;

	assign cdb_valid   = cdb.valid;
	assign cdb_rob_tag = cdb.rob_tag;
	assign cdb_value   = cdb.value;

endmodule

// ==== design/exec_writeback.sv ====
//////////////////////////////////////////////////////////////////////
// top of the execute and write-back slice
// issue ports to both units, both slots to the cdb arbiter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_writeback import exec_writeback_pkg::*; (
	input logic      clock,
	input logic      reset,
	input logic      issue_valid,
	input logic      issue_is_load,
	input rob_tag_t  issue_rob_tag,
	input op_field_t issue_op,
	input xlen_t     issue_rs1_value,
	input xlen_t     issue_rs2_value,
	input xlen_t     issue_imm,
	output logic     alu_ready,
	output logic     load_ready,
	output logic     mem_read,
	output xlen_t    mem_addr,
	input xlen_t     mem_data,
	output logic     cdb_valid,
	output rob_tag_t cdb_rob_tag,
	output xlen_t    cdb_value
);

	issue_if   issue_bus ();
	wr_slot_if alu_slot_bus ();
	wr_slot_if load_slot_bus ();

	// issue ports onto the shared issue bus
	assign issue_bus.valid     = issue_valid;
	assign issue_bus.is_load   = issue_is_load;
	assign issue_bus.rob_tag   = issue_rob_tag;
	assign issue_bus.op        = issue_op;
	assign issue_bus.rs1_value = issue_rs1_value;
	assign issue_bus.rs2_value = issue_rs2_value;
	assign issue_bus.imm       = issue_imm;

	//////////////////////////////////////////////////////////////////////
	// execute units
	//////////////////////////////////////////////////////////////////////

	alu_unit alu_unit_i (
		.clock     (clock),
		.reset     (reset),
		.issue     (issue_bus.sink),
		.slot      (alu_slot_bus.source),
		.alu_ready (alu_ready)
	);

	load_unit load_unit_i (
		.clock      (clock),
		.reset      (reset),
		.issue      (issue_bus.sink),
		.slot       (load_slot_bus.source),
		.load_ready (load_ready),
		.mem_read   (mem_read),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data)
	);

	// write stage
	cdb_arbiter cdb_arbiter_i (
		.alu_slot    (alu_slot_bus.arb),
		.load_slot   (load_slot_bus.arb),
		.cdb_valid   (cdb_valid),
		.cdb_rob_tag (cdb_rob_tag),
		.cdb_value   (cdb_value)
	);

endmodule

// ==== tb/exec_writeback_assertions.sv ====
//////////////////////////////////////////////////////////////////////
// concurrent assertions on the slice top level
// reset quiet, single-beat reads, load stall, held alu slot
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_writeback_assertions import exec_writeback_pkg::*; (
	input logic     clock,
	input logic     reset,
	input logic     alu_ready,
	input logic     load_ready,
	input logic     mem_read,
	input logic     cdb_valid,
	input rob_tag_t cdb_rob_tag,
	input rob_tag_t alu_slot_rob_tag
);

	// quiet once reset has been seen on two edges
	reset_quiet: assert property (@(posedge clock)
		reset && $past(reset) |-> !cdb_valid && !mem_read)
		else $error("cdb_valid or mem_read high during reset");

	// one request in flight, one cycle each
	single_beat_read: assert property (@(posedge clock) disable iff (reset)
		mem_read |=> !mem_read)
		else $error("mem_read high two cycles in a row");

	load_stall: assert property (@(posedge clock) disable iff (reset)
		mem_read |-> !load_ready)
		else $error("load_ready high with a read outstanding");

	// alu held means the load took the cdb, the alu tag goes next
	held_alu_slot: assert property (@(posedge clock) disable iff (reset)
		!alu_ready |=> cdb_valid && cdb_rob_tag == $past(alu_slot_rob_tag))
		else $error("held alu slot tag did not reach the CDB next cycle");

endmodule

// ==== tb/exec_writeback_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the execute and write-back slice
// golden-file driver, memory model, cdb and address checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_writeback_tb import exec_writeback_pkg::*; ();

	localparam int NUM_VECTORS = 16;
	// eight cycles per vector covers gaps, stalls and load latency
	localparam int CYCLE_LIMIT = NUM_VECTORS * 8 + 100;
	localparam int TAG_COUNT = 2 ** $bits(rob_tag_t);
	localparam xlen_t MEM_PATTERN = 32'hc3a5_0f1e;

	logic      clock;
	logic      reset;
	logic      issue_valid;
	logic      issue_is_load;
	rob_tag_t  issue_rob_tag;
	op_field_t issue_op;
	xlen_t     issue_rs1_value;
	xlen_t     issue_rs2_value;
	xlen_t     issue_imm;
	logic      alu_ready;
	logic      load_ready;
	logic      mem_read;
	xlen_t     mem_addr;
	xlen_t     mem_data;
	logic      cdb_valid;
	rob_tag_t  cdb_rob_tag;
	xlen_t     cdb_value;

	// scoreboard indexed by tag
	xlen_t    expected [TAG_COUNT];
	bit       issued [TAG_COUNT];
	bit       seen [TAG_COUNT];
	int       cdb_order [TAG_COUNT];
	// word addresses of accepted loads in issue order
	xlen_t    addr_queue [$];
	// load then alu accepted on back-to-back edges
	rob_tag_t pair_load [$];
	rob_tag_t pair_alu [$];

	int          cycle = 0;
	int          cdb_beats = 0;
	int          issue_count = 0;
	int          vector_count = 0;
	int          mismatch_count = 0;
	int          failure_count = 0;
	logic [31:0] lcg_state;

	exec_writeback exec_writeback_i (
		.clock           (clock),
		.reset           (reset),
		.issue_valid     (issue_valid),
		.issue_is_load   (issue_is_load),
		.issue_rob_tag   (issue_rob_tag),
		.issue_op        (issue_op),
		.issue_rs1_value (issue_rs1_value),
		.issue_rs2_value (issue_rs2_value),
		.issue_imm       (issue_imm),
		.alu_ready       (alu_ready),
		.load_ready      (load_ready),
		.mem_read        (mem_read),
		.mem_addr        (mem_addr),
		.mem_data        (mem_data),
		.cdb_valid       (cdb_valid),
		.cdb_rob_tag     (cdb_rob_tag),
		.cdb_value       (cdb_value)
	);

	bind exec_writeback exec_writeback_assertions assertions_i (
		.clock            (clock),
		.reset            (reset),
		.alu_ready        (alu_ready),
		.load_ready       (load_ready),
		.mem_read         (mem_read),
		.cdb_valid        (cdb_valid),
		.cdb_rob_tag      (cdb_rob_tag),
		.alu_slot_rob_tag (alu_unit_i.slot_rob_tag)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d of %0d results seen on the CDB",
				CYCLE_LIMIT, cdb_beats, issue_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	task automatic check_cdb(input cdb_packet_t pkt);
		if (issue_count == 0) begin
			failure_count++;
			$display("CDB valid at %0t before anything was issued", $time);
		end else if (!issued[pkt.rob_tag]) begin
			failure_count++;
			$display("CDB carried tag %0d at %0t that was never issued", pkt.rob_tag, $time);
		end else if (seen[pkt.rob_tag]) begin
			failure_count++;
			$display("CDB carried tag %0d a second time at %0t", pkt.rob_tag, $time);
		end else begin
			seen[pkt.rob_tag] = 1'b1;
			cdb_order[pkt.rob_tag] = cdb_beats;
			cdb_beats++;
			if (pkt.value !== expected[pkt.rob_tag]) begin
				mismatch_count++;
				$display("MISMATCH at %0t: CDB tag %0d value %h, expected %h",
					$time, pkt.rob_tag, pkt.value, expected[pkt.rob_tag]);
			end
		end
	endtask

	task automatic check_mem_addr(input xlen_t actual, input xlen_t wanted);
		if (actual !== wanted) begin
			mismatch_count++;
			$display("MISMATCH at %0t: mem_addr %h, expected %h", $time, actual, wanted);
		end
	endtask

	// memory model and cdb monitor on the falling edge where outputs have settled
	always @(negedge clock) begin
		cdb_packet_t pkt;
		if (!reset) begin
			if (mem_read) begin
				// data for the edge that closes the read cycle
				mem_data = mem_addr ^ MEM_PATTERN;
				if (addr_queue.size() == 0) begin
					failure_count++;
					$display("memory read at %0t without an accepted load", $time);
				end else begin
					check_mem_addr(mem_addr, addr_queue.pop_front());
				end
			end
			if (cdb_valid) begin
				pkt.valid   = cdb_valid;
				pkt.rob_tag = cdb_rob_tag;
				pkt.value   = cdb_value;
				check_cdb(pkt);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// driver
	//////////////////////////////////////////////////////////////////////

	// hold the vector until its unit is ready and return after the accepting edge
	task automatic issue_vector(input logic is_load, input rob_tag_t tag, input op_field_t op,
			input xlen_t rs1, input xlen_t rs2, input xlen_t imm, output logic at_once);
		@(negedge clock);
		issue_valid     = 1'b1;
		issue_is_load   = is_load;
		issue_rob_tag   = tag;
		issue_op        = op;
		issue_rs1_value = rs1;
		issue_rs2_value = rs2;
		issue_imm       = imm;
		issued[tag]     = 1'b1;
		issue_count++;
		at_once = is_load ? load_ready : alu_ready;
		while (!(is_load ? load_ready : alu_ready)) begin
			@(negedge clock);
		end
		@(posedge clock);
		// word-aligned effective address
		if (is_load) begin
			addr_queue.push_back((rs1 + imm) & 32'hffff_fffc);
		end
	endtask

	initial begin
		int       fd;
		string    line;
		int       fields;
		int       kind;
		int       tag;
		int       op;
		xlen_t    rs1;
		xlen_t    rs2;
		xlen_t    imm;
		xlen_t    value;
		int       gap;
		logic     at_once;
		logic     prev_load;
		rob_tag_t prev_tag;
		issue_valid     = 1'b0;
		issue_is_load   = 1'b0;
		issue_rob_tag   = '0;
		issue_op        = '0;
		issue_rs1_value = '0;
		issue_rs2_value = '0;
		issue_imm       = '0;
		mem_data        = '0;
		reset           = 1'b1;
		lcg_state       = 32'hea61;
		prev_load       = 1'b0;
		prev_tag        = '0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		// quiet cycles with nothing issued yet
		repeat (2) @(negedge clock);
		fd = $fopen("tb/exec_writeback_golden.txt", "r");
		if (fd == 0) begin
			failure_count++;
			$display("cannot open tb/exec_writeback_golden.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				fields = $sscanf(line, "%h %h %h %h %h %h %h",
					kind, tag, op, rs1, rs2, imm, value);
				// comment and blank lines
				if (fields != 7) begin
					continue;
				end
				expected[tag] = value;
				vector_count++;
				// no gap after a load so an alu result meets it at the write stage
				if (!prev_load && vector_count > 1) begin
					lcg_state = next_random(lcg_state);
					gap = int'(lcg_state[17:16]);
					if (gap > 0) begin
						@(negedge clock);
						issue_valid = 1'b0;
						repeat (gap - 1) @(negedge clock);
					end
				end
				issue_vector(kind == 1, rob_tag_t'(tag), op_field_t'(op), rs1, rs2, imm,
					at_once);
				if (prev_load && kind == 0 && at_once) begin
					pair_load.push_back(prev_tag);
					pair_alu.push_back(rob_tag_t'(tag));
				end
				prev_load = (kind == 1);
				prev_tag  = rob_tag_t'(tag);
			end
			$fclose(fd);
		end
		@(negedge clock);
		issue_valid = 1'b0;
		wait (cdb_beats == issue_count);
		// a few idle cycles to catch a repeated beat
		repeat (6) @(negedge clock);
		if (vector_count != NUM_VECTORS) begin
			failure_count++;
			$display("golden file held %0d vectors instead of %0d", vector_count, NUM_VECTORS);
		end
		if (pair_load.size() == 0) begin
			failure_count++;
			$display("no load and alu result ever met at the write stage");
		end
		// the held alu result follows the load on the next beat
		foreach (pair_load[i]) begin
			if (cdb_order[pair_alu[i]] != cdb_order[pair_load[i]] + 1) begin
				failure_count++;
				$display("alu tag %0d did not directly follow load tag %0d on the CDB",
					pair_alu[i], pair_load[i]);
			end
		end
		if (addr_queue.size() != 0) begin
			failure_count++;
			$display("%0d accepted loads never raised mem_read", addr_queue.size());
		end
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== tb/exec_writeback_golden.txt ====
# kind (0 alu, 1 load), rob tag, op, rs1, rs2, imm, expected cdb value, all hex
# load data is the word address xor c3a50f1e
0 00 0 12345678 11111111 00000000 23456789
1 0a 0 00001000 00000000 00000003 ffffffc3
0 01 1 00000005 00000007 00000000 fffffffe
0 02 2 f0f0ff00 0ff0f0f0 00000000 00f0f000
1 0b 8 00002000 00000000 00000001 0000002f
0 03 3 f0000000 0000000f 00000000 f000000f
1 0c 2 00000ffe 00000000 00000004 ffffc3a5
1 0d a 00008000 00000000 00000000 00008f1e
0 04 4 aaaa5555 ffff0000 00000000 55555555
0 05 5 00000001 00000024 00000000 00000010
1 0e 4 10000010 00000000 fffffff4 d3a50f1a
0 06 6 80000000 0000001f 00000000 00000001
0 07 7 80000000 00000004 00000000 f8000000
1 0f 0 00000040 00000000 00000002 ffffffa5
0 08 8 ffffffff 00000001 00000000 00000001
0 09 9 ffffffff 00000001 00000000 00000000

// ==== exec_writeback.f ====
+incdir+include
design/exec_writeback_pkg.sv
design/exec_if.sv
design/alu_unit.sv
design/load_unit.sv
design/cdb_arbiter.sv
design/exec_writeback.sv
tb/exec_writeback_assertions.sv
tb/exec_writeback_tb.sv

// ==== Makefile ====
# Verilator build and run for the execute and write-back slice

VERILATOR ?= verilator
TOP       ?= exec_writeback_tb
FILELIST  ?= exec_writeback.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= TEST PASS

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv include/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
